// ==== include/usys_defines.svh ====
`ifndef USYS_DEFINES_SVH
`define USYS_DEFINES_SVH

// Array shape. Rows set the dot-product length.
`define USYS_ROWS 3
`define USYS_COLS 4

// Weight magnitude and random number width.
`define USYS_IWIDTH 4

// Signed partial-sum width.
`define USYS_OWIDTH 12

// Bits per input stream, 2**USYS_IWIDTH.
`define USYS_STREAM_LEN 16

`endif

// ==== logic/usys_pkg.sv ====
`default_nettype none

`include "usys_defines.svh"

package usys_pkg;

    // Sign-magnitude weight.
    typedef struct packed {
        logic                      sign;
        logic [`USYS_IWIDTH-1:0]   mag;
    } wght_t;

    // Per-PE control, forwarded east one register per PE.
    typedef struct packed {
        logic clr_w;
        logic en_w;
        logic clr_o;
        logic en_o;
        logic en_i;
        logic mac_done;
    } pe_ctrl_t;

    // Row stream bit and its low-discrepancy number.
    typedef struct packed {
        logic                      ifm;
        logic [`USYS_IWIDTH-1:0]   rand_w;
    } row_in_t;

    // Partial sum travelling south.
    typedef struct packed {
        logic                            valid;
        logic signed [`USYS_OWIDTH-1:0]  sum;
    } psum_t;

endpackage

`default_nettype wire

// ==== logic/pe_acc.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "usys_defines.svh"

module pe_acc (
    input  wire logic              clk,
    input  wire logic              reset_i,
    input  wire logic              clr_i,
    input  wire logic              en_i,
    input  wire logic              mac_done_i,
    input  wire logic              prod_i,
    input  wire logic              neg_i,
    input  wire usys_pkg::psum_t   psum_i,
    output usys_pkg::psum_t        psum_o
);

    logic signed [`USYS_OWIDTH-1:0] cnt_q;
    logic signed [`USYS_OWIDTH-1:0] sum_q;
    logic                           valid_q;

    // Up/down count of product bits.
    always_ff @(posedge clk) begin
        if (reset_i || clr_i) begin
            cnt_q <= '0;
        end else if (en_i && prod_i) begin
            if (neg_i) begin
                cnt_q <= cnt_q - 1'b1;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= mac_done_i;
        end
    end

    // Merge into the north sum.
    always_ff @(posedge clk) begin
        if (mac_done_i) begin
            sum_q <= psum_i.sum + cnt_q;
        end
    end

    assign psum_o.valid = valid_q;
    assign psum_o.sum   = sum_q;

    a_en_done : assert property (@(posedge clk) disable iff (reset_i)
        !(en_i && mac_done_i));

    // North sum must land on this row's done cycle.
    a_psum_align : assert property (@(posedge clk) disable iff (reset_i)
        psum_i.valid |-> mac_done_i);

endmodule

`default_nettype wire

// ==== logic/pe_inner.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "usys_defines.svh"

module pe_inner (
    input  wire logic                 clk,
    input  wire logic                 reset_i,
    input  wire usys_pkg::pe_ctrl_t   ctrl_i,
    input  wire usys_pkg::row_in_t    row_i,
    input  wire usys_pkg::wght_t      wght_i,
    input  wire usys_pkg::psum_t      psum_i,
    output usys_pkg::pe_ctrl_t        ctrl_o,
    output usys_pkg::row_in_t         row_o,
    output usys_pkg::wght_t           wght_o,
    output usys_pkg::psum_t           psum_o
);

    usys_pkg::pe_ctrl_t          ctrl_q;
    usys_pkg::wght_t             wght_q;
    usys_pkg::wght_t             wght_fwd;
    logic                        ifm_q;
    logic [`USYS_IWIDTH-1:0]     rand_q;
    logic                        prod;

    // Control moves east one PE per cycle.
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ctrl_q <= '0;
        end else begin
            ctrl_q <= ctrl_i;
        end
    end

    // Input bit register.
    always_ff @(posedge clk) begin
        if (ctrl_i.clr_o) begin
            ifm_q <= 1'b0;
        end else if (ctrl_i.en_i) begin
            ifm_q <= row_i.ifm;
        end
    end

    always_ff @(posedge clk) begin
        rand_q <= row_i.rand_w;
    end

    // The old weight goes south, so the column shifts by one row per load.
    always_ff @(posedge clk) begin
        if (ctrl_i.en_w) begin
            wght_q   <= wght_i;
            wght_fwd <= ctrl_i.clr_w ? '0 : wght_q;
        end else if (ctrl_i.clr_w) begin
            wght_q   <= '0;
            wght_fwd <= '0;
        end
    end

    // Unary multiply.
    assign prod = ifm_q & (wght_q.mag > rand_q);

    pe_acc u_acc (
        .clk        (clk),
        .reset_i    (reset_i),
        .clr_i      (ctrl_q.clr_o),
        .en_i       (ctrl_q.en_o),
        .mac_done_i (ctrl_q.mac_done),
        .prod_i     (prod),
        .neg_i      (wght_q.sign),
        .psum_i     (psum_i),
        .psum_o     (psum_o)
    );

    assign ctrl_o       = ctrl_q;
    assign row_o.ifm    = ifm_q;
    assign row_o.rand_w = rand_q;
    assign wght_o       = wght_fwd;

endmodule

`default_nettype wire

// ==== logic/pe_array.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "usys_defines.svh"

module pe_array (
    input  wire logic                                  clk,
    input  wire logic                                  reset_i,
    input  wire usys_pkg::pe_ctrl_t [`USYS_ROWS-1:0]   row_ctrl_i,
    input  wire usys_pkg::row_in_t [`USYS_ROWS-1:0]    row_in_i,
    input  wire usys_pkg::wght_t [`USYS_COLS-1:0]      wght_i,
    output usys_pkg::psum_t [`USYS_COLS-1:0]           res_o
);

    // East links carry one spare entry past the last column.
    usys_pkg::pe_ctrl_t  ctrl_w [`USYS_ROWS][`USYS_COLS+1];
    usys_pkg::row_in_t   row_w  [`USYS_ROWS][`USYS_COLS+1];
    usys_pkg::wght_t     wght_w [`USYS_ROWS+1][`USYS_COLS];
    usys_pkg::psum_t     psum_w [`USYS_ROWS+1][`USYS_COLS];

    for (genvar r = 0; r < `USYS_ROWS; r++) begin : g_west
        assign ctrl_w[r][0] = row_ctrl_i[r];
        assign row_w[r][0]  = row_in_i[r];
    end

    for (genvar c = 0; c < `USYS_COLS; c++) begin : g_north
        assign wght_w[0][c] = wght_i[c];
        // Top row starts from an empty sum.
        assign psum_w[0][c] = '0;
        assign res_o[c]     = psum_w[`USYS_ROWS][c];
    end

    for (genvar r = 0; r < `USYS_ROWS; r++) begin : g_r
        for (genvar c = 0; c < `USYS_COLS; c++) begin : g_c
            pe_inner u_pe (
                .clk     (clk),
                .reset_i (reset_i),
                .ctrl_i  (ctrl_w[r][c]),
                .row_i   (row_w[r][c]),
                .wght_i  (wght_w[r][c]),
                .psum_i  (psum_w[r][c]),
                .ctrl_o  (ctrl_w[r][c+1]),
                .row_o   (row_w[r][c+1]),
                .wght_o  (wght_w[r+1][c]),
                .psum_o  (psum_w[r+1][c])
            );
        end
    end

endmodule

`default_nettype wire

// ==== logic/usys_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "usys_defines.svh"

module usys_ctrl (
    input  wire logic                                    clk,
    input  wire logic                                    reset_i,
    input  wire logic                                    start_i,
    input  wire logic                                    wght_load_i,
    input  wire usys_pkg::wght_t [`USYS_COLS-1:0]        wght_row_i,
    input  wire logic [`USYS_ROWS-1:0]                   ifm_i,
    output logic                                         take_o,
    output logic                                         busy_o,
    output usys_pkg::pe_ctrl_t [`USYS_ROWS-1:0]          row_ctrl_o,
    output usys_pkg::row_in_t [`USYS_ROWS-1:0]           row_in_o,
    output usys_pkg::wght_t [`USYS_COLS-1:0]             wght_o
);

    // Drain covers the row skew, the column skew and the sum registers.
    localparam int unsigned DRAIN_LEN = `USYS_ROWS + `USYS_COLS + 2;
    localparam int unsigned CNT_W     = $clog2(`USYS_STREAM_LEN + DRAIN_LEN);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CLEAR,
        ST_STREAM,
        ST_DRAIN
    } state_t;

    state_t                                   st;
    logic [CNT_W-1:0]                         cnt;
    logic                                     start_ok;
    logic                                     load_ok;
    logic                                     wclr_pend;
    logic [`USYS_IWIDTH-1:0]                  ones [`USYS_ROWS];
    usys_pkg::pe_ctrl_t                       ctrl_nxt;
    usys_pkg::pe_ctrl_t                       ctrl_dly [`USYS_ROWS];
    usys_pkg::row_in_t [`USYS_ROWS-1:0]       in_dly [`USYS_ROWS];
    usys_pkg::wght_t [`USYS_COLS-1:0]         wdly [`USYS_COLS];

    function automatic logic [`USYS_IWIDTH-1:0] bit_rev(input logic [`USYS_IWIDTH-1:0] v);
        logic [`USYS_IWIDTH-1:0] r;
        for (int i = 0; i < `USYS_IWIDTH; i++) begin
            r[i] = v[`USYS_IWIDTH-1-i];
        end
        return r;
    endfunction

    assign busy_o   = (st != ST_IDLE);
    assign take_o   = (st == ST_STREAM);
    assign start_ok = (st == ST_IDLE) && start_i;
    assign load_ok  = (st == ST_IDLE) && wght_load_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            st  <= ST_IDLE;
            cnt <= '0;
        end else begin
            case (st)
                ST_IDLE: begin
                    if (start_i) begin
                        st <= ST_CLEAR;
                    end
                end
                ST_CLEAR: begin
                    st  <= ST_STREAM;
                    cnt <= '0;
                end
                ST_STREAM: begin
                    if (cnt == CNT_W'(`USYS_STREAM_LEN - 1)) begin
                        st  <= ST_DRAIN;
                        cnt <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                ST_DRAIN: begin
                    if (cnt == CNT_W'(DRAIN_LEN - 1)) begin
                        st <= ST_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: st <= ST_IDLE;
            endcase
        end
    end

    // Row-0 control word for the coming cycle.
    always_comb begin
        ctrl_nxt          = '0;
        ctrl_nxt.clr_w    = wclr_pend;
        ctrl_nxt.en_w     = load_ok;
        ctrl_nxt.clr_o    = start_ok;
        ctrl_nxt.en_i     = take_o;
        ctrl_nxt.en_o     = take_o;
        ctrl_nxt.mac_done = (st == ST_DRAIN) && (cnt == '0);
    end

    // Weights get one clear pass once reset is released.
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int r = 0; r < `USYS_ROWS; r++) begin
                ctrl_dly[r] <= '0;
            end
            wclr_pend <= 1'b1;
        end else begin
            ctrl_dly[0] <= ctrl_nxt;
            for (int r = 1; r < `USYS_ROWS; r++) begin
                ctrl_dly[r] <= ctrl_dly[r-1];
            end
            wclr_pend <= 1'b0;
        end
    end

    // Per-row one counts seen before the current bit.
    always_ff @(posedge clk) begin
        if (reset_i || start_ok) begin
            for (int r = 0; r < `USYS_ROWS; r++) begin
                ones[r] <= '0;
            end
        end else if (take_o) begin
            for (int r = 0; r < `USYS_ROWS; r++) begin
                ones[r] <= ones[r] + `USYS_IWIDTH'(ifm_i[r]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_o) begin
            for (int r = 0; r < `USYS_ROWS; r++) begin
                in_dly[0][r].ifm    <= ifm_i[r];
                in_dly[0][r].rand_w <= bit_rev(ones[r]);
            end
        end
        for (int d = 1; d < `USYS_ROWS; d++) begin
            in_dly[d] <= in_dly[d-1];
        end
    end

    // Column c of the weight row lags by c, matching en_w moving east.
    always_ff @(posedge clk) begin
        if (load_ok) begin
            wdly[0] <= wght_row_i;
        end
        for (int d = 1; d < `USYS_COLS; d++) begin
            wdly[d] <= wdly[d-1];
        end
    end

    for (genvar r = 0; r < `USYS_ROWS; r++) begin : g_row
        assign row_ctrl_o[r] = ctrl_dly[r];
        assign row_in_o[r]   = in_dly[r][r];
    end

    for (genvar c = 0; c < `USYS_COLS; c++) begin : g_col
        assign wght_o[c] = wdly[c][c];
    end

    a_take_len : assert property (@(posedge clk) disable iff (reset_i)
        $rose(take_o) |-> (take_o && busy_o) [*`USYS_STREAM_LEN] ##1 !take_o);

    // Once a run is under way, a load strobe must not reach the array.
    a_load_idle : assert property (@(posedge clk) disable iff (reset_i)
        busy_o [*`USYS_COLS + 1] |-> !row_ctrl_o[0].en_w && $stable(wght_o));

endmodule

`default_nettype wire

// ==== logic/usys_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "usys_defines.svh"

module usys_top (
    input  wire logic                                  clk,
    input  wire logic                                  reset_i,
    input  wire logic                                  start_i,
    input  wire logic                                  wght_load_i,
    input  wire usys_pkg::wght_t [`USYS_COLS-1:0]      wght_row_i,
    input  wire logic [`USYS_ROWS-1:0]                 ifm_i,
    output logic                                       take_o,
    output logic                                       busy_o,
    output usys_pkg::psum_t [`USYS_COLS-1:0]           res_o
);

    usys_pkg::pe_ctrl_t [`USYS_ROWS-1:0]  row_ctrl;
    usys_pkg::row_in_t [`USYS_ROWS-1:0]   row_in;
    usys_pkg::wght_t [`USYS_COLS-1:0]     wght;

    // Sequencing, random numbers and row skew.
    usys_ctrl u_ctrl (
        .clk         (clk),
        .reset_i     (reset_i),
        .start_i     (start_i),
        .wght_load_i (wght_load_i),
        .wght_row_i  (wght_row_i),
        .ifm_i       (ifm_i),
        .take_o      (take_o),
        .busy_o      (busy_o),
        .row_ctrl_o  (row_ctrl),
        .row_in_o    (row_in),
        .wght_o      (wght)
    );

    pe_array u_array (
        .clk        (clk),
        .reset_i    (reset_i),
        .row_ctrl_i (row_ctrl),
        .row_in_i   (row_in),
        .wght_i     (wght),
        .res_o      (res_o)
    );

endmodule

`default_nettype wire

// ==== test/tb_usys_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "usys_defines.svh"

module tb_usys_top;

    localparam int RUN_CYCLES  = `USYS_STREAM_LEN + `USYS_ROWS + `USYS_COLS + 12;
    localparam int LOAD_CYCLES = 2 * `USYS_ROWS + 4;
    // Thirty runs with their loads, plus reset and margin.
    localparam int MAX_CYCLES  = 30 * (RUN_CYCLES + LOAD_CYCLES) + 200;

    logic                                  clk;
    logic                                  reset_i;
    logic                                  start_i;
    logic                                  wght_load_i;
    usys_pkg::wght_t [`USYS_COLS-1:0]      wght_row_i;
    logic [`USYS_ROWS-1:0]                 ifm_i;
    logic                                  take_o;
    logic                                  busy_o;
    usys_pkg::psum_t [`USYS_COLS-1:0]      res_o;

    int                                    seed;
    int                                    cycle_cnt = 0;
    int                                    take_cnt;
    int                                    valid_cnt [`USYS_COLS];
    usys_pkg::wght_t                       w_model [`USYS_ROWS][`USYS_COLS];
    logic [`USYS_STREAM_LEN-1:0]           stream [`USYS_ROWS];
    usys_pkg::psum_t                       exp_res [`USYS_COLS];

    usys_top DUT (
        .clk         (clk),
        .reset_i     (reset_i),
        .start_i     (start_i),
        .wght_load_i (wght_load_i),
        .wght_row_i  (wght_row_i),
        .ifm_i       (ifm_i),
        .take_o      (take_o),
        .busy_o      (busy_o),
        .res_o       (res_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    task automatic abort_run();
        $display("TEST FAIL");
        $fatal(1, "Stopped at the first error.");
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: the runs did not finish within %0d cycles.", MAX_CYCLES);
            abort_run();
        end
    end

    task automatic check_psum(input string name, input usys_pkg::psum_t got,
                              input usys_pkg::psum_t exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s: got valid=%0b sum=%0d, expected valid=%0b sum=%0d",
                     $time, name, got.valid, got.sum, exp.valid, exp.sum);
            abort_run();
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s: got %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("[FAIL] t=%0t %s: got %0d, expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    // Shift in from the LSB so v[0] ends up as the MSB.
    function automatic logic [`USYS_IWIDTH-1:0] reverse_bits(input logic [`USYS_IWIDTH-1:0] v);
        logic [`USYS_IWIDTH-1:0] r;
        r = '0;
        for (int i = 0; i < `USYS_IWIDTH; i++) begin
            r = {r[`USYS_IWIDTH-2:0], v[i]};
        end
        return r;
    endfunction

    // Expected dot product of one column from the stored weights and streams.
    function automatic logic signed [`USYS_OWIDTH-1:0] ref_column(input int c);
        int                       acc;
        logic [`USYS_IWIDTH-1:0]  ones;
        acc = 0;
        for (int r = 0; r < `USYS_ROWS; r++) begin
            ones = '0;
            for (int t = 0; t < `USYS_STREAM_LEN; t++) begin
                if (stream[r][t] && (w_model[r][c].mag > reverse_bits(ones))) begin
                    acc = w_model[r][c].sign ? acc - 1 : acc + 1;
                end
                if (stream[r][t]) begin
                    ones = ones + 1'b1;
                end
            end
        end
        return `USYS_OWIDTH'(acc);
    endfunction

    function automatic logic signed [`USYS_OWIDTH-1:0] mag_sum(input int c);
        int acc;
        acc = 0;
        for (int r = 0; r < `USYS_ROWS; r++) begin
            if (w_model[r][c].sign) begin
                acc = acc - int'(w_model[r][c].mag);
            end else begin
                acc = acc + int'(w_model[r][c].mag);
            end
        end
        return `USYS_OWIDTH'(acc);
    endfunction

    // Mode 0 uses the reference, 1 the magnitude sum, others zero.
    task automatic set_expect(input int mode);
        for (int c = 0; c < `USYS_COLS; c++) begin
            exp_res[c].valid = 1'b1;
            case (mode)
                0: exp_res[c].sum = ref_column(c);
                1: exp_res[c].sum = mag_sum(c);
                default: exp_res[c].sum = '0;
            endcase
        end
    endtask

    // Newest row enters at row 0, older rows move south.
    task automatic load_row(input usys_pkg::wght_t [`USYS_COLS-1:0] row);
        @(posedge clk);
        #1;
        wght_load_i = 1'b1;
        wght_row_i  = row;
        @(posedge clk);
        #1;
        wght_load_i = 1'b0;
        for (int r = `USYS_ROWS - 1; r > 0; r--) begin
            for (int c = 0; c < `USYS_COLS; c++) begin
                w_model[r][c] = w_model[r-1][c];
            end
        end
        for (int c = 0; c < `USYS_COLS; c++) begin
            w_model[0][c] = row[c];
        end
    endtask

    task automatic load_rows(input int n, input logic zero);
        usys_pkg::wght_t [`USYS_COLS-1:0] row;
        logic [31:0]                      rnd;
        for (int i = 0; i < n; i++) begin
            for (int c = 0; c < `USYS_COLS; c++) begin
                rnd = $random(seed);
                row[c].sign = zero ? 1'b0 : rnd[4];
                row[c].mag  = zero ? '0 : rnd[3:0];
            end
            load_row(row);
        end
    endtask

    // Kind 0 is random, 1 all ones, 2 all zeros.
    task automatic fill_streams(input int kind);
        for (int r = 0; r < `USYS_ROWS; r++) begin
            case (kind)
                1: stream[r] = '1;
                2: stream[r] = '0;
                default: stream[r] = `USYS_STREAM_LEN'($random(seed));
            endcase
        end
    endtask

    task automatic run_stream(input logic strobe_busy);
        int          k;
        logic [31:0] rnd;
        take_cnt = 0;
        for (int c = 0; c < `USYS_COLS; c++) begin
            valid_cnt[c] = 0;
        end
        @(posedge clk);
        #1;
        start_i = 1'b1;
        @(posedge clk);
        #1;
        start_i = 1'b0;
        check_level("busy_o", busy_o, 1'b1);
        k = 0;
        while (k < `USYS_STREAM_LEN) begin
            @(posedge clk);
            #1;
            start_i     = 1'b0;
            wght_load_i = 1'b0;
            if (take_o) begin
                for (int r = 0; r < `USYS_ROWS; r++) begin
                    ifm_i[r] = stream[r][k];
                end
                k++;
                // These strobes land mid-stream and must be dropped.
                if (strobe_busy && k == 6) begin
                    rnd         = $random(seed);
                    start_i     = 1'b1;
                    wght_load_i = 1'b1;
                    wght_row_i  = rnd[$bits(wght_row_i)-1:0];
                end
            end
        end
        @(posedge clk);
        #1;
        ifm_i = '0;
        @(negedge clk);
        while (busy_o) begin
            @(negedge clk);
        end
        check_count("take_o high cycles", take_cnt, `USYS_STREAM_LEN);
        for (int c = 0; c < `USYS_COLS; c++) begin
            check_count($sformatf("res_o[%0d] valid pulses", c), valid_cnt[c], 1);
        end
    endtask

    // Compare on the falling edge, away from the DUT's updates.
    always @(negedge clk) begin
        if (!reset_i) begin
            if (take_o) begin
                take_cnt++;
                check_level("busy_o", busy_o, 1'b1);
            end
            for (int c = 0; c < `USYS_COLS; c++) begin
                if (res_o[c].valid) begin
                    check_psum($sformatf("res_o[%0d]", c), res_o[c], exp_res[c]);
                    valid_cnt[c]++;
                end
            end
        end
    end

    initial begin
        seed        = 30;
        reset_i     = 1'b1;
        start_i     = 1'b0;
        wght_load_i = 1'b0;
        wght_row_i  = '0;
        ifm_i       = '0;
        take_cnt    = 0;
        for (int c = 0; c < `USYS_COLS; c++) begin
            valid_cnt[c] = 0;
            exp_res[c]   = '0;
            for (int r = 0; r < `USYS_ROWS; r++) begin
                w_model[r][c] = '0;
            end
        end
        fill_streams(2);
        repeat (10) @(posedge clk);
        #1;
        reset_i = 1'b0;

        @(negedge clk);
        check_level("busy_o", busy_o, 1'b0);
        check_level("take_o", take_o, 1'b0);
        for (int c = 0; c < `USYS_COLS; c++) begin
            check_level($sformatf("res_o[%0d].valid", c), res_o[c].valid, 1'b0);
        end
        // Let the weight clear sweep the grid.
        repeat (`USYS_ROWS + `USYS_COLS + 2) @(posedge clk);

        // All-ones streams count each magnitude once.
        load_rows(`USYS_ROWS, 1'b0);
        fill_streams(1);
        set_expect(1);
        run_stream(1'b0);

        for (int i = 0; i < 25; i++) begin
            load_rows(i % `USYS_ROWS + 1, 1'b0);
            fill_streams(0);
            set_expect(0);
            run_stream(1'b0);
        end

        load_rows(`USYS_ROWS, 1'b0);
        fill_streams(0);
        set_expect(0);
        run_stream(1'b1);
        // Same weights again, so the dropped load is visible here.
        fill_streams(0);
        set_expect(0);
        run_stream(1'b0);

        load_rows(`USYS_ROWS, 1'b1);
        fill_streams(0);
        set_expect(2);
        run_stream(1'b0);

        load_rows(`USYS_ROWS, 1'b0);
        fill_streams(2);
        set_expect(2);
        run_stream(1'b0);

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
logic/usys_pkg.sv
logic/pe_acc.sv
logic/pe_inner.sv
logic/pe_array.sv
logic/usys_ctrl.sv
logic/usys_top.sv
test/tb_usys_top.sv
